/* ccu_pkg.sv */
package ccu_pkg;

    // ====================
    // Widths
    // ====================
    localparam int WORD_W  = 128;
    localparam int OP_W    = 3;
    localparam int LEN_W   = 8;   // Layer count
    localparam int NIP_W   = 16;  // Input points
    localparam int CHI_W   = 12;  // Input channels
    localparam int SCALE_W = 20;
    localparam int ACT_W   = 8;   // Shift and zero point
    localparam int SMOD_W  = 2;   // SYA mode
    localparam int K_W     = 5;

    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [OP_W-1:0] {
        OP_ARRAY = 3'd0,
        OP_CONV  = 3'd1,
        OP_FC    = 3'd2,  // Skipped, no layer
        OP_POOL  = 3'd3,
        OP_FPS   = 3'd4,
        OP_KNN   = 3'd5
    } opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_FETCH,
        ST_ENGINE
    } state_t;

    typedef enum logic [1:0] {
        ENG_SYA,
        ENG_POL,
        ENG_CTR,
        ENG_NONE  // Array or skipped opcode
    } engine_e;

    // ====================
    // Engine payloads
    // ====================
    typedef struct packed {
        logic [NIP_W-1:0]   nip;
        logic [CHI_W-1:0]   chi;
        logic [SCALE_W-1:0] scale;
        logic [ACT_W-1:0]   shift;
        logic [ACT_W-1:0]   zp;
        logic [SMOD_W-1:0]  mode;
    } sya_cfg_t;  // 66 bits

    typedef struct packed {
        logic [NIP_W-1:0] nip;
        logic [CHI_W-1:0] chi;
        logic [K_W-1:0]   k;
    } pol_cfg_t;  // 33 bits

    typedef struct packed {
        logic             mode;  // 0 FPS, 1 KNN
        logic [NIP_W-1:0] nip;
        logic [NIP_W-1:0] nop;
        logic [K_W-1:0]   k;
    } ctr_cfg_t;  // 38 bits

    // ====================
    // Field LSBs per word
    // ====================
    localparam int OP_LSB         = 0;
    localparam int ARR_LEN_LSB    = 3;
    localparam int CONV_NIP_LSB   = 3;   // Word 0
    localparam int CONV_CHI_LSB   = 19;
    localparam int CONV_SCALE_LSB = 0;   // Word 1
    localparam int CONV_SHIFT_LSB = 20;
    localparam int CONV_ZP_LSB    = 28;
    localparam int CONV_MODE_LSB  = 36;
    localparam int POOL_NIP_LSB   = 3;
    localparam int POOL_CHI_LSB   = 19;
    localparam int POOL_K_LSB     = 31;
    localparam int FPS_NIP_LSB    = 3;
    localparam int FPS_NOP_LSB    = 19;
    localparam int KNN_NIP_LSB    = 3;
    localparam int KNN_K_LSB      = 19;

endpackage

/* isa_buffer.sv */
`timescale 1ns/1ps

module isa_buffer #(
    parameter int ISA_DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    input  logic           wr_en,
    input  ccu_pkg::word_t wr_word,
    input  logic           fetch,
    output ccu_pkg::word_t rd_word,
    output logic           word_vld,
    output logic           full,
    output logic           empty
);

    localparam int AW = $clog2(ISA_DEPTH);

    ccu_pkg::word_t mem [ISA_DEPTH];
    logic [AW:0]    wr_ptr;  // Extra MSB tells full from empty
    logic [AW:0]    rd_ptr;

    // Pointers, cleared while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_vld <= 1'b0;
        end else begin
            word_vld <= fetch;  // Read data lands next cycle
            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_en)
                    wr_ptr <= wr_ptr + 1'b1;
                if (fetch)
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Dual-port RAM, registered read
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[AW-1:0]] <= wr_word;
        if (fetch)
            rd_word <= mem[rd_ptr[AW-1:0]];
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);  // Wrapped once

endmodule

/* isa_counters.sv */
`timescale 1ns/1ps

module isa_counters (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     word_step,
    input  logic                     instr_last,
    input  logic                     layer_step,
    input  logic [ccu_pkg::LEN_W-1:0] prog_len,
    output logic                     word_idx,
    output logic                     prog_done
);

    logic [ccu_pkg::LEN_W-1:0] layer_cnt;
    logic [ccu_pkg::LEN_W-1:0] layer_nxt;

    // Word within the current instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            word_idx <= 1'b0;
        else if (clear || instr_last)
            word_idx <= 1'b0;  // Next word opens a new instruction
        else if (word_step)
            word_idx <= 1'b1;
    end

    // Accepted layers in this program
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            layer_cnt <= '0;
        else if (clear)
            layer_cnt <= '0;
        else if (layer_step)
            layer_cnt <= layer_nxt;
    end

    // Count including a step in this cycle, so the FSM decides on cfg_done
    assign layer_nxt = layer_cnt + ccu_pkg::LEN_W'(layer_step);
    assign prog_done = (layer_nxt == prog_len);

endmodule

/* ccu_fsm.sv */
`timescale 1ns/1ps

module ccu_fsm (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             full,
    input  logic             empty,
    input  logic             word_vld,
    input  logic             instr_last,
    input  ccu_pkg::engine_e eng_sel,
    input  logic             cfg_done,
    input  logic             prog_done,
    output ccu_pkg::state_t  state,
    output logic             fetch,
    output logic             isa_rdy,
    output logic             clear,
    output logic             layer_step,
    output logic             eng_rst
);

    ccu_pkg::state_t nxt;

    // ====================
    // Next state
    // ====================
    always_comb begin
        nxt = state;
        case (state)
            ccu_pkg::ST_IDLE:
                if (start)
                    nxt = ccu_pkg::ST_FILL;
            ccu_pkg::ST_FILL:
                if (full)
                    nxt = ccu_pkg::ST_FETCH;  // Buffer loaded, start decode
            ccu_pkg::ST_FETCH:
                if (word_vld) begin
                    if (instr_last && eng_sel != ccu_pkg::ENG_NONE)
                        nxt = ccu_pkg::ST_ENGINE;
                    else if (instr_last && prog_done)
                        nxt = ccu_pkg::ST_IDLE;
                    else if (empty)
                        nxt = ccu_pkg::ST_FILL;  // Refill, also mid-instruction
                end
            ccu_pkg::ST_ENGINE:
                if (cfg_done) begin
                    if (prog_done)
                        nxt = ccu_pkg::ST_IDLE;  // Last layer taken
                    else if (empty)
                        nxt = ccu_pkg::ST_FILL;
                    else
                        nxt = ccu_pkg::ST_FETCH;
                end
            default:
                nxt = ccu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ccu_pkg::ST_IDLE;
        else
            state <= nxt;
    end

    // ====================
    // Strobes and levels
    // ====================
    // One fetch, then one cycle for the word to come back
    assign fetch      = (state == ccu_pkg::ST_FETCH) && !word_vld;
    assign isa_rdy    = (state == ccu_pkg::ST_FILL) && !full;
    assign clear      = (state == ccu_pkg::ST_IDLE);  // Pointers and counters
    assign layer_step = (state == ccu_pkg::ST_ENGINE) && cfg_done;
    assign eng_rst    = (state == ccu_pkg::ST_IDLE);  // Engines held while idle

endmodule

/* isa_decoder.sv */
`timescale 1ns/1ps

module isa_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      word_vld,
    input  ccu_pkg::word_t            rd_word,
    input  logic                      word_idx,
    output logic                      instr_last,
    output ccu_pkg::engine_e          eng_sel,
    output logic [ccu_pkg::LEN_W-1:0] prog_len,
    output logic                      sya_load,
    output ccu_pkg::sya_cfg_t         sya_pay,
    output logic                      pol_load,
    output ccu_pkg::pol_cfg_t         pol_cfg,
    output logic                      ctr_load,
    output ccu_pkg::ctr_cfg_t         ctr_cfg
);

    ccu_pkg::opcode_t          op_q;    // Opcode of the open instruction
    ccu_pkg::opcode_t          cur_op;
    logic [ccu_pkg::LEN_W-1:0] len_q;
    logic                      arr_hit;

    // Word 0 carries the opcode, later words reuse the latched one
    assign cur_op = word_idx ? op_q
                             : ccu_pkg::opcode_t'(rd_word[ccu_pkg::OP_LSB +: ccu_pkg::OP_W]);

    // Only Conv spans two words
    assign instr_last = word_vld && (word_idx || cur_op != ccu_pkg::OP_CONV);

    always_comb begin
        case (cur_op)
            ccu_pkg::OP_CONV:               eng_sel = ccu_pkg::ENG_SYA;
            ccu_pkg::OP_POOL:               eng_sel = ccu_pkg::ENG_POL;
            ccu_pkg::OP_FPS, ccu_pkg::OP_KNN: eng_sel = ccu_pkg::ENG_CTR;
            ccu_pkg::OP_ARRAY, ccu_pkg::OP_FC: eng_sel = ccu_pkg::ENG_NONE;
            default:                        eng_sel = ccu_pkg::ENG_NONE;  // 6 and 7
        endcase
    end

    // Bypass so the done check at the Array word already sees N
    assign arr_hit  = word_vld && cur_op == ccu_pkg::OP_ARRAY;
    assign prog_len = arr_hit ? rd_word[ccu_pkg::ARR_LEN_LSB +: ccu_pkg::LEN_W] : len_q;

    // ====================
    // Control registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q     <= ccu_pkg::OP_ARRAY;
            len_q    <= '0;
            sya_load <= 1'b0;
            pol_load <= 1'b0;
            ctr_load <= 1'b0;
        end else begin
            if (word_vld && !word_idx)
                op_q <= cur_op;
            if (arr_hit)
                len_q <= prog_len;
            sya_load <= instr_last && eng_sel == ccu_pkg::ENG_SYA;  // Payload complete
            pol_load <= instr_last && eng_sel == ccu_pkg::ENG_POL;
            ctr_load <= instr_last && eng_sel == ccu_pkg::ENG_CTR;
        end
    end

    // ====================
    // Field extraction
    // ====================
    always_ff @(posedge clk) begin
        if (word_vld) begin
            case (cur_op)
                ccu_pkg::OP_CONV:
                    if (!word_idx) begin
                        sya_pay.nip <= rd_word[ccu_pkg::CONV_NIP_LSB +: ccu_pkg::NIP_W];
                        sya_pay.chi <= rd_word[ccu_pkg::CONV_CHI_LSB +: ccu_pkg::CHI_W];
                    end else begin
                        sya_pay.scale <= rd_word[ccu_pkg::CONV_SCALE_LSB +: ccu_pkg::SCALE_W];
                        sya_pay.shift <= rd_word[ccu_pkg::CONV_SHIFT_LSB +: ccu_pkg::ACT_W];
                        sya_pay.zp    <= rd_word[ccu_pkg::CONV_ZP_LSB +: ccu_pkg::ACT_W];
                        sya_pay.mode  <= rd_word[ccu_pkg::CONV_MODE_LSB +: ccu_pkg::SMOD_W];
                    end
                ccu_pkg::OP_POOL: begin
                    pol_cfg.nip <= rd_word[ccu_pkg::POOL_NIP_LSB +: ccu_pkg::NIP_W];
                    pol_cfg.chi <= rd_word[ccu_pkg::POOL_CHI_LSB +: ccu_pkg::CHI_W];
                    pol_cfg.k   <= rd_word[ccu_pkg::POOL_K_LSB +: ccu_pkg::K_W];
                end
                ccu_pkg::OP_FPS: begin
                    ctr_cfg.mode <= 1'b0;
                    ctr_cfg.nip  <= rd_word[ccu_pkg::FPS_NIP_LSB +: ccu_pkg::NIP_W];
                    ctr_cfg.nop  <= rd_word[ccu_pkg::FPS_NOP_LSB +: ccu_pkg::NIP_W];
                    ctr_cfg.k    <= '0;  // Unused by FPS
                end
                ccu_pkg::OP_KNN: begin
                    ctr_cfg.mode <= 1'b1;
                    ctr_cfg.nip  <= rd_word[ccu_pkg::KNN_NIP_LSB +: ccu_pkg::NIP_W];
                    ctr_cfg.nop  <= '0;  // Unused by KNN
                    ctr_cfg.k    <= rd_word[ccu_pkg::KNN_K_LSB +: ccu_pkg::K_W];
                end
                default: ;
            endcase
        end
    end

endmodule

/* cfg_port.sv */
`timescale 1ns/1ps

module cfg_port #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  PAYLOAD_T pay_in,
    output PAYLOAD_T pay_out,
    output logic     cfg_vld,
    input  logic     cfg_rdy,
    output logic     cfg_done
);

    // Valid rises with the payload, drops after the handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cfg_vld <= 1'b0;
        else if (load)
            cfg_vld <= 1'b1;
        else if (cfg_rdy)
            cfg_vld <= 1'b0;
    end

    // Held unchanged while the engine stalls
    always_ff @(posedge clk) begin
        if (load)
            pay_out <= pay_in;
    end

    assign cfg_done = cfg_vld && cfg_rdy;  // One-cycle accept pulse

endmodule

/* ccu_top.sv */
`timescale 1ns/1ps

module ccu_top #(
    parameter int ISA_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  ccu_pkg::word_t    isa_dat,
    input  logic              isa_vld,
    output logic              isa_rdy,
    output logic              eng_rst,
    output ccu_pkg::sya_cfg_t sya_cfg,
    output logic              sya_cfg_vld,
    input  logic              sya_cfg_rdy,
    output ccu_pkg::pol_cfg_t pol_cfg,
    output logic              pol_cfg_vld,
    input  logic              pol_cfg_rdy,
    output ccu_pkg::ctr_cfg_t ctr_cfg,
    output logic              ctr_cfg_vld,
    input  logic              ctr_cfg_rdy
);

    // ====================
    // Internal nets
    // ====================
    ccu_pkg::word_t            rd_word;
    ccu_pkg::engine_e          eng_sel;
    ccu_pkg::sya_cfg_t         dec_sya;
    ccu_pkg::pol_cfg_t         dec_pol;
    ccu_pkg::ctr_cfg_t         dec_ctr;
    logic [ccu_pkg::LEN_W-1:0] prog_len;
    logic                      clear;
    logic                      wr_en;
    logic                      fetch;
    logic                      word_vld;
    logic                      full;
    logic                      empty;
    logic                      word_idx;
    logic                      instr_last;
    logic                      layer_step;
    logic                      prog_done;
    logic                      sya_load;
    logic                      pol_load;
    logic                      ctr_load;
    logic                      sya_done;
    logic                      pol_done;
    logic                      ctr_done;
    logic                      cfg_done;

    assign wr_en    = isa_vld && isa_rdy;  // Host word accepted
    assign cfg_done = sya_done || pol_done || ctr_done;

    isa_buffer #(.ISA_DEPTH(ISA_DEPTH)) i_isa_buffer (
        .clk, .rst_n, .clear, .wr_en, .wr_word(isa_dat),
        .fetch, .rd_word, .word_vld, .full, .empty
    );

    isa_counters i_isa_counters (
        .clk, .rst_n, .clear, .word_step(word_vld), .instr_last,
        .layer_step, .prog_len, .word_idx, .prog_done
    );

    ccu_fsm i_ccu_fsm (
        .clk, .rst_n, .start, .full, .empty, .word_vld, .instr_last, .eng_sel,
        .cfg_done, .prog_done, .state(), .fetch, .isa_rdy, .clear, .layer_step, .eng_rst
    );

    isa_decoder i_isa_decoder (
        .clk, .rst_n, .word_vld, .rd_word, .word_idx, .instr_last, .eng_sel, .prog_len,
        .sya_load, .sya_pay(dec_sya), .pol_load, .pol_cfg(dec_pol),
        .ctr_load, .ctr_cfg(dec_ctr)
    );

    // One holding port per engine
    cfg_port #(.PAYLOAD_T(ccu_pkg::sya_cfg_t)) i_sya_port (
        .clk, .rst_n, .load(sya_load), .pay_in(dec_sya), .pay_out(sya_cfg),
        .cfg_vld(sya_cfg_vld), .cfg_rdy(sya_cfg_rdy), .cfg_done(sya_done)
    );

    cfg_port #(.PAYLOAD_T(ccu_pkg::pol_cfg_t)) i_pol_port (
        .clk, .rst_n, .load(pol_load), .pay_in(dec_pol), .pay_out(pol_cfg),
        .cfg_vld(pol_cfg_vld), .cfg_rdy(pol_cfg_rdy), .cfg_done(pol_done)
    );

    cfg_port #(.PAYLOAD_T(ccu_pkg::ctr_cfg_t)) i_ctr_port (
        .clk, .rst_n, .load(ctr_load), .pay_in(dec_ctr), .pay_out(ctr_cfg),
        .cfg_vld(ctr_cfg_vld), .cfg_rdy(ctr_cfg_rdy), .cfg_done(ctr_done)
    );

endmodule

/* tb_ccu_assert.sv */
`timescale 1ns/1ps

module tb_ccu_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              isa_rdy,
    input logic              eng_rst,
    input ccu_pkg::sya_cfg_t sya_cfg,
    input logic              sya_cfg_vld,
    input logic              sya_cfg_rdy,
    input ccu_pkg::pol_cfg_t pol_cfg,
    input logic              pol_cfg_vld,
    input logic              pol_cfg_rdy,
    input ccu_pkg::ctr_cfg_t ctr_cfg,
    input logic              ctr_cfg_vld,
    input logic              ctr_cfg_rdy
);

    int fail_cnt = 0;  // Summed into the closing count

    // ====================
    // Held engine configs
    // ====================
    sya_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld && !sya_cfg_rdy |=> sya_cfg_vld && $stable(sya_cfg))
    else begin
        fail_cnt++;
        $error("SYA config dropped or changed before ready");
    end

    pol_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pol_cfg_vld && !pol_cfg_rdy |=> pol_cfg_vld && $stable(pol_cfg))
    else begin
        fail_cnt++;
        $error("POL config dropped or changed before ready");
    end

    ctr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ctr_cfg_vld && !ctr_cfg_rdy |=> ctr_cfg_vld && $stable(ctr_cfg))
    else begin
        fail_cnt++;
        $error("CTR config dropped or changed before ready");
    end

    // No host fill while engines sit in reset or a config waits
    idle_no_fill: assert property (@(posedge clk) disable iff (!rst_n)
        !(isa_rdy && (eng_rst || sya_cfg_vld || pol_cfg_vld || ctr_cfg_vld)))
    else begin
        fail_cnt++;
        $error("isa_rdy high while eng_rst high or a config pending");
    end

endmodule

/* tb_ccu.sv */
`timescale 1ns/1ps

module tb_ccu;

    localparam int ISA_DEPTH    = 8;
    localparam int NUM_PROGS    = 5;
    localparam int CYC_PER_PROG = 400;
    localparam int RST_CYCLES   = 10;
    localparam int TIMEOUT      = RST_CYCLES + NUM_PROGS * CYC_PER_PROG;

    logic              clk;
    logic              rst_n;
    logic              start;
    ccu_pkg::word_t    isa_dat;
    logic              isa_vld;
    logic              isa_rdy;
    logic              eng_rst;
    ccu_pkg::sya_cfg_t sya_cfg;
    logic              sya_cfg_vld;
    logic              sya_cfg_rdy;
    ccu_pkg::pol_cfg_t pol_cfg;
    logic              pol_cfg_vld;
    logic              pol_cfg_rdy;
    ccu_pkg::ctr_cfg_t ctr_cfg;
    logic              ctr_cfg_vld;
    logic              ctr_cfg_rdy;

    // ====================
    // Model state
    // ====================
    ccu_pkg::word_t host_q [$];     // Words the host streams in
    ccu_pkg::word_t exp_q [3][$];   // Expected payloads, one queue per engine
    int             eng_q [$];      // Engine order across the program
    string          eng_name [3] = '{"SYA", "POL", "CTR"};
    integer         seed;
    int             host_idx  = 0;
    int             fill_cnt  = 0;  // Rising edges of isa_rdy
    int             cycle_cnt = 0;
    int             mism_cnt  = 0;
    int             other_cnt = 0;
    logic           rdy_q     = 1'b0;
    logic           prog_over = 1'b0;  // Set between programs

    ccu_top #(.ISA_DEPTH(ISA_DEPTH)) i_ccu_top (.*);

    bind ccu_top tb_ccu_assert i_ccu_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Random filler, low 40 bits left free for fields
    function automatic ccu_pkg::word_t junk_word();
        ccu_pkg::word_t w;
        w = {next_rand(), next_rand(), next_rand(), next_rand()};
        w[39:0] = '0;
        return w;
    endfunction

    // ====================
    // Program generator
    // ====================
    task automatic build_program(input int p);
        int                n;
        logic [1:0]        op;
        logic [95:0]       f;
        ccu_pkg::word_t    w;
        ccu_pkg::sya_cfg_t s;
        ccu_pkg::pol_cfg_t pc;
        ccu_pkg::ctr_cfg_t c;
        host_q.delete();
        n = (p == NUM_PROGS - 1) ? 6 : 1 + int'(next_rand() % 6);
        w = junk_word();
        w[2:0]  = 3'd0;  // Array
        w[10:3] = n[7:0];
        host_q.push_back(w);
        for (int i = 0; i < n; i++) begin
            f = {next_rand(), next_rand(), next_rand()};
            if (f[93:91] == 3'd0) begin  // FC or opcode 7, no layer
                w = junk_word();
                w[2:0] = f[90] ? 3'd2 : 3'd7;
                host_q.push_back(w);
            end
            // Last program leans on Conv so it spans a refill
            op = (p == NUM_PROGS - 1 && i % 2 == 0) ? 2'd0 : f[95:94];
            w  = junk_word();
            w[18:3] = f[15:0];  // nip, same place for all four
            case (op)
                2'd0: begin
                    s.nip   = f[15:0];
                    s.chi   = f[27:16];
                    s.scale = f[47:28];
                    s.shift = f[55:48];
                    s.zp    = f[63:56];
                    s.mode  = f[65:64];
                    w[2:0]   = 3'd1;
                    w[30:19] = s.chi;
                    host_q.push_back(w);
                    w = junk_word();  // Second Conv word
                    w[19:0]  = s.scale;
                    w[27:20] = s.shift;
                    w[35:28] = s.zp;
                    w[37:36] = s.mode;
                    exp_q[0].push_back(ccu_pkg::word_t'(s));
                    eng_q.push_back(int'(ccu_pkg::ENG_SYA));
                end
                2'd1: begin
                    pc.nip = f[15:0];
                    pc.chi = f[27:16];
                    pc.k   = f[32:28];
                    w[2:0]   = 3'd3;
                    w[30:19] = pc.chi;
                    w[35:31] = pc.k;
                    exp_q[1].push_back(ccu_pkg::word_t'(pc));
                    eng_q.push_back(int'(ccu_pkg::ENG_POL));
                end
                default: begin
                    c.mode = (op == 2'd3);  // KNN
                    c.nip  = f[15:0];
                    c.nop  = c.mode ? 16'd0 : f[31:16];
                    c.k    = c.mode ? f[36:32] : 5'd0;
                    w[2:0] = c.mode ? 3'd5 : 3'd4;
                    if (c.mode)
                        w[23:19] = c.k;
                    else
                        w[34:19] = c.nop;
                    exp_q[2].push_back(ccu_pkg::word_t'(c));
                    eng_q.push_back(int'(ccu_pkg::ENG_CTR));
                end
            endcase
            host_q.push_back(w);
        end
        while (host_q.size() % ISA_DEPTH != 0) begin
            w = junk_word();
            w[2:0] = 3'd6;  // Padding, never fetched
            host_q.push_back(w);
        end
    endtask

    task automatic check_accept(input int e, input ccu_pkg::word_t got);
        ccu_pkg::word_t exp;
        int             exp_eng;
        assert (exp_q[e].size() > 0 && eng_q.size() > 0) else begin
            other_cnt++;
            $display("Error at %0t: %s took a config the program does not hold",
                     $time, eng_name[e]);
        end
        if (exp_q[e].size() > 0 && eng_q.size() > 0) begin
            exp     = exp_q[e].pop_front();
            exp_eng = eng_q.pop_front();
            assert (exp_eng == e) else begin
                mism_cnt++;
                $display("Mismatch at %0t: %s config out of order, expected %s next",
                         $time, eng_name[e], eng_name[exp_eng]);
            end
            assert (got == exp) else begin
                mism_cnt++;
                $display("Mismatch at %0t: %s payload got %h expected %h",
                         $time, eng_name[e], got, exp);
            end
        end
    endtask

    // ====================
    // Drivers and monitor
    // ====================
    always @(posedge clk) begin
        logic [31:0] r;
        #1;
        r = next_rand();
        isa_vld     = (host_idx < host_q.size()) && (r[1:0] != 2'd0);
        isa_dat     = (host_idx < host_q.size()) ? host_q[host_idx] : '0;
        sya_cfg_rdy = r[2];  // Random engine stalls
        pol_cfg_rdy = r[3];
        ctr_cfg_rdy = r[4];
    end

    // Mid-cycle sampling, inputs settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (isa_vld && isa_rdy)
                host_idx++;  // Written at the coming edge
            if (isa_rdy && !rdy_q)
                fill_cnt++;
            rdy_q = isa_rdy;
            assert (!prog_over || !(sya_cfg_vld || pol_cfg_vld || ctr_cfg_vld)) else begin
                other_cnt++;
                $display("Error at %0t: config offered after the program ended", $time);
            end
            if (sya_cfg_vld && sya_cfg_rdy)
                check_accept(int'(ccu_pkg::ENG_SYA), ccu_pkg::word_t'(sya_cfg));
            if (pol_cfg_vld && pol_cfg_rdy)
                check_accept(int'(ccu_pkg::ENG_POL), ccu_pkg::word_t'(pol_cfg));
            if (ctr_cfg_vld && ctr_cfg_rdy)
                check_accept(int'(ccu_pkg::ENG_CTR), ccu_pkg::word_t'(ctr_cfg));
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Error at %0t: timeout after %0d cycles, program never finished",
                     $time, cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        seed        = 25774;
        rst_n       = 1'b0;
        start       = 1'b0;
        isa_dat     = '0;
        isa_vld     = 1'b0;
        sya_cfg_rdy = 1'b0;
        pol_cfg_rdy = 1'b0;
        ctr_cfg_rdy = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!isa_rdy && !sya_cfg_vld && !pol_cfg_vld && !ctr_cfg_vld && eng_rst)
        else begin
            mism_cnt++;
            $display("Mismatch at %0t: outputs after reset not idle", $time);
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            #2;
            build_program(p);
            host_idx = 0;
            fill_cnt = 0;
            @(posedge clk);
            #1;
            start     = 1'b1;
            prog_over = 1'b0;
            @(posedge clk);
            #1;
            start = 1'b0;
            @(negedge clk);
            while (!eng_rst)
                @(negedge clk);  // Back in idle after the last layer
            prog_over = 1'b1;
            assert (exp_q[0].size() == 0 && exp_q[1].size() == 0 &&
                    exp_q[2].size() == 0 && eng_q.size() == 0) else begin
                other_cnt++;
                $display("Error at %0t: program %0d ended with configs still expected",
                         $time, p);
            end
            assert (host_idx == host_q.size()) else begin
                mism_cnt++;
                $display("Mismatch at %0t: host words taken %0d expected %0d",
                         $time, host_idx, host_q.size());
            end
            assert (fill_cnt == host_q.size() / ISA_DEPTH) else begin
                mism_cnt++;
                $display("Mismatch at %0t: fill phases %0d expected %0d",
                         $time, fill_cnt, host_q.size() / ISA_DEPTH);
            end
            repeat (4) @(negedge clk);  // Quiet window, stray configs flagged
        end
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mism_cnt, other_cnt, i_ccu_top.i_ccu_assert.fail_cnt);
        if (mism_cnt + other_cnt + i_ccu_top.i_ccu_assert.fail_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* files.f */
ccu_pkg.sv
isa_buffer.sv
isa_counters.sv
ccu_fsm.sv
isa_decoder.sv
cfg_port.sv
ccu_top.sv
tb_ccu_assert.sv
tb_ccu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ccu
FLAGS     ?= --assert --timing
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
